//--- design/rpc_router_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

module rpc_router_crossbar #(
	parameter int         CHILD_COUNT      = 2,
	parameter logic [3:0] NEIGHBOR_PRESENT = 4'b1111,
	parameter logic [3:0] X_POS            = 4'd0,
	parameter logic [3:0] Y_POS            = 4'd0,
	parameter int         FIFO_DEPTH       = 8,
	localparam int        TOTAL_PORTS      = rpc_router_pkg::NEIGHBOR_COUNT + CHILD_COUNT
) (
	input  wire                                         clk,
	input  wire                                         rst_n,
	input  rpc_router_pkg::rpc_link_t [TOTAL_PORTS-1:0] in_link,
	output logic [TOTAL_PORTS-1:0]                      in_ready,
	output rpc_router_pkg::rpc_link_t [TOTAL_PORTS-1:0] out_link,
	input  logic [TOTAL_PORTS-1:0]                      out_ready
);
	import rpc_router_pkg::*;

	//////////////////////////////////////////////////
	// Crossbar wiring

	// All FIFO heads, packed by input port
	logic [TOTAL_PORTS*WORD_W-1:0] head_bus;

	logic [$clog2(FIFO_DEPTH):0] fifo_level [TOTAL_PORTS];
	logic [TOTAL_PORTS-1:0]      fifo_rd;

	// Receive side view, indexed [input][output]
	logic [TOTAL_PORTS-1:0] rx_req   [TOTAL_PORTS];
	logic [TOTAL_PORTS-1:0] rx_grant [TOTAL_PORTS];
	logic [TOTAL_PORTS-1:0] rx_take  [TOTAL_PORTS];

	// Arbiter view, indexed [output][input]
	logic [TOTAL_PORTS-1:0] arb_req   [TOTAL_PORTS];
	logic [TOTAL_PORTS-1:0] arb_grant [TOTAL_PORTS];
	logic [TOTAL_PORTS-1:0] arb_take  [TOTAL_PORTS];

	//////////////////////////////////////////////////
	// Input side, one FIFO and one decoder per port

	for (genvar s = 0; s < TOTAL_PORTS; s++) begin : g_in
		rpc_rx_fifo #(
			.FIFO_DEPTH (FIFO_DEPTH)
		) i_rx_fifo (
			.clk      (clk),
			.rst_n    (rst_n),
			.wr_link  (in_link[s]),
			.wr_ready (in_ready[s]),
			.rd       (fifo_rd[s]),
			.dout     (head_bus[s*WORD_W +: WORD_W]),
			.level    (fifo_level[s])
		);

		rpc_rx_port #(
			.CHILD_COUNT      (CHILD_COUNT),
			.NEIGHBOR_PRESENT (NEIGHBOR_PRESENT),
			.X_POS            (X_POS),
			.Y_POS            (Y_POS),
			.FIFO_DEPTH       (FIFO_DEPTH)
		) i_rx_port (
			.clk   (clk),
			.rst_n (rst_n),
			.head  (head_bus[s*WORD_W +: WORD_W]),
			.level (fifo_level[s]),
			.rd    (fifo_rd[s]),
			.req   (rx_req[s]),
			.grant (rx_grant[s]),
			.take  (rx_take[s])
		);
	end

	//////////////////////////////////////////////////
	// Output side, outputs pull from the heads

	for (genvar o = 0; o < TOTAL_PORTS; o++) begin : g_out
		rpc_tx_arbiter #(
			.CHILD_COUNT (CHILD_COUNT)
		) i_tx_arbiter (
			.clk       (clk),
			.rst_n     (rst_n),
			.req       (arb_req[o]),
			.src_data  (head_bus),
			.grant     (arb_grant[o]),
			.take      (arb_take[o]),
			.out_link  (out_link[o]),
			.out_ready (out_ready[o])
		);
	end

	// Transpose request, grant and take matrices
	for (genvar s = 0; s < TOTAL_PORTS; s++) begin : g_row
		for (genvar o = 0; o < TOTAL_PORTS; o++) begin : g_col
			assign arb_req[o][s]  = rx_req[s][o];
			assign rx_grant[s][o] = arb_grant[o][s];
			assign rx_take[s][o]  = arb_take[o][s];
		end
	end

endmodule

`default_nettype wire

//--- design/rpc_router_pkg.sv
`default_nettype none

package rpc_router_pkg;

	//////////////////////////////////////////////////
	// Link geometry

	// Width of one link word
	localparam int WORD_W = 32;

	// Every message is four words long
	localparam int MESSAGE_WORDS = 4;

	//////////////////////////////////////////////////
	// Address and link types

	// Destination address in the upper half of the first word
	typedef struct packed {
		logic [3:0] x;
		logic [3:0] y;
		logic [7:0] child;
	} rpc_addr_t;

	// Forward half of a link, ready runs the other way
	typedef struct packed {
		logic              valid;
		logic [WORD_W-1:0] data;
	} rpc_link_t;

	//////////////////////////////////////////////////
	// Port numbering

	// Neighbors first, children from index 4 upward
	localparam logic [1:0] PORT_WEST  = 2'd0;
	localparam logic [1:0] PORT_EAST  = 2'd1;
	localparam logic [1:0] PORT_SOUTH = 2'd2;
	localparam logic [1:0] PORT_NORTH = 2'd3;

	localparam int NEIGHBOR_COUNT = 4;

endpackage

`default_nettype wire

//--- design/rpc_rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rpc_rx_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  wire                             clk,
	input  wire                             rst_n,
	input  rpc_router_pkg::rpc_link_t       wr_link,
	output logic                            wr_ready,
	input  logic                            rd,
	output logic [rpc_router_pkg::WORD_W-1:0] dout,
	output logic [$clog2(FIFO_DEPTH):0]     level
);
	import rpc_router_pkg::*;

	// Pointer width, depth is a power of two so pointers wrap on their own
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	//////////////////////////////////////////////////
	// Storage and pointers

	logic [WORD_W-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic              wr_en;

	// Accept while there is room
	assign wr_ready = (level != (PTR_W+1)'(FIFO_DEPTH));
	assign wr_en    = wr_link.valid & wr_ready;

	// Show-ahead, head word always on dout
	assign dout = mem[rd_ptr];

	// Data array
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_link.data;
		end
	end

	//////////////////////////////////////////////////
	// Pointer and level bookkeeping

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Level is words written less words popped
			case ({wr_en, rd})
				2'b10: begin
					level <= level + 1'b1;
				end
				2'b01: begin
					level <= level - 1'b1;
				end
				default: begin
					// Push and pop together, or neither
					level <= level;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- design/rpc_rx_port.sv
`timescale 1ns/1ps
`default_nettype none

module rpc_rx_port #(
	parameter int         CHILD_COUNT      = 2,
	parameter logic [3:0] NEIGHBOR_PRESENT = 4'b1111,
	parameter logic [3:0] X_POS            = 4'd0,
	parameter logic [3:0] Y_POS            = 4'd0,
	parameter int         FIFO_DEPTH       = 8,
	localparam int        TOTAL_PORTS      = rpc_router_pkg::NEIGHBOR_COUNT + CHILD_COUNT
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  logic [rpc_router_pkg::WORD_W-1:0] head,
	input  logic [$clog2(FIFO_DEPTH):0]       level,
	output logic                              rd,
	output logic [TOTAL_PORTS-1:0]            req,
	input  logic [TOTAL_PORTS-1:0]            grant,
	input  logic [TOTAL_PORTS-1:0]            take
);
	import rpc_router_pkg::*;

	localparam int CNT_W = $clog2(MESSAGE_WORDS);

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_DECIDE,
		RX_REQUEST,
		RX_SEND,
		RX_DROP
	} rx_state_t;

	rx_state_t               state;
	rpc_addr_t               head_addr;
	logic [1:0]              nbr_idx;
	logic [TOTAL_PORTS-1:0]  route_onehot;
	logic                    route_ok;
	logic [TOTAL_PORTS-1:0]  dest_q;
	logic [CNT_W-1:0]        drop_cnt;

	//////////////////////////////////////////////////
	// Header decode and routing rule

	assign head_addr = head[WORD_W-1 -: $bits(rpc_addr_t)];

	// X first, then Y
	assign nbr_idx = (head_addr.x > X_POS) ? PORT_EAST :
		(head_addr.x < X_POS) ? PORT_WEST :
		(head_addr.y > Y_POS) ? PORT_NORTH : PORT_SOUTH;

	always_comb begin
		route_onehot = '0;
		route_ok     = 1'b0;
		if (head_addr.x == X_POS && head_addr.y == Y_POS) begin
			// Local, out of range child indices match nothing
			for (int c = 0; c < CHILD_COUNT; c++) begin
				if (int'(head_addr.child) == c) begin
					route_onehot[NEIGHBOR_COUNT + c] = 1'b1;
					route_ok = 1'b1;
				end
			end
		end else begin
			route_onehot[nbr_idx] = 1'b1;
			// Absent neighbor means drop
			route_ok = NEIGHBOR_PRESENT[nbr_idx];
		end
	end

	//////////////////////////////////////////////////
	// Message state machine

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= RX_IDLE;
			dest_q   <= '0;
			drop_cnt <= '0;
		end else begin
			case (state)
				RX_IDLE: begin
					// Wait for a whole message in the FIFO
					if (level >= MESSAGE_WORDS) begin
						state <= RX_DECIDE;
					end
				end
				RX_DECIDE: begin
					dest_q   <= route_onehot;
					drop_cnt <= '0;
					state    <= route_ok ? RX_REQUEST : RX_DROP;
				end
				RX_REQUEST: begin
					// Takes may already start in this cycle
					if (|grant) begin
						state <= RX_SEND;
					end
				end
				RX_SEND: begin
					// Arbiter drops grant after the last word
					if (!(|grant)) begin
						state <= RX_IDLE;
					end
				end
				RX_DROP: begin
					drop_cnt <= drop_cnt + 1'b1;
					if (drop_cnt == CNT_W'(MESSAGE_WORDS - 1)) begin
						state <= RX_IDLE;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Outputs

	// Request stays up until the grant ends, then falls with it
	always_comb begin
		case (state)
			RX_REQUEST: req = dest_q;
			RX_SEND:    req = dest_q & grant;
			default:    req = '0;
		endcase
	end

	// Pop on any word taken by an output, or while discarding
	assign rd = (state == RX_DROP) | (|take);

endmodule

`default_nettype wire

//--- design/rpc_tx_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rpc_tx_arbiter #(
	parameter int  CHILD_COUNT = 2,
	localparam int TOTAL_PORTS = rpc_router_pkg::NEIGHBOR_COUNT + CHILD_COUNT
) (
	input  wire                                           clk,
	input  wire                                           rst_n,
	input  logic [TOTAL_PORTS-1:0]                        req,
	input  logic [TOTAL_PORTS*rpc_router_pkg::WORD_W-1:0] src_data,
	output logic [TOTAL_PORTS-1:0]                        grant,
	output logic [TOTAL_PORTS-1:0]                        take,
	output rpc_router_pkg::rpc_link_t                     out_link,
	input  logic                                          out_ready
);
	import rpc_router_pkg::*;

	localparam int SEL_W = $clog2(TOTAL_PORTS);
	localparam int CNT_W = $clog2(MESSAGE_WORDS);

	logic [SEL_W-1:0] ptr;
	logic [SEL_W-1:0] sel;
	logic [CNT_W-1:0] word_cnt;
	logic             busy;
	logic             accept;
	logic             win_found;
	logic [SEL_W-1:0] win_idx;

	//////////////////////////////////////////////////
	// Round-robin pick

	// First requester at or after the pointer
	always_comb begin
		int cand;
		win_found = 1'b0;
		win_idx   = '0;
		for (int k = 0; k < TOTAL_PORTS; k++) begin
			cand = (int'(ptr) + k) % TOTAL_PORTS;
			if (!win_found && req[cand]) begin
				win_found = 1'b1;
				win_idx   = SEL_W'(cand);
			end
		end
	end

	//////////////////////////////////////////////////
	// Word mux

	assign busy   = |grant;
	assign accept = busy & out_ready;

	// Granted source's head word straight onto the link
	assign out_link.valid = busy;
	assign out_link.data  = src_data[int'(sel)*WORD_W +: WORD_W];

	// One-hot take back to the source that moved a word
	assign take = accept ? grant : '0;

	//////////////////////////////////////////////////
	// Grant and word count

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant    <= '0;
			sel      <= '0;
			ptr      <= '0;
			word_cnt <= '0;
		end else if (!busy) begin
			// Idle, lock onto a winner for a whole message
			if (win_found) begin
				grant          <= '0;
				grant[win_idx] <= 1'b1;
				sel            <= win_idx;
				word_cnt       <= '0;
			end
		end else if (accept) begin
			word_cnt <= word_cnt + 1'b1;
			if (word_cnt == CNT_W'(MESSAGE_WORDS - 1)) begin
				// Last word, release and rotate past the winner
				grant <= '0;
				if (sel == SEL_W'(TOTAL_PORTS - 1)) begin
					ptr <= '0;
				end else begin
					ptr <= sel + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module rpc_router_tb -f sim.f -o Vrpc_router_tb

output="$(./obj_dir/Vrpc_router_tb)"
echo "$output"

if grep -qxF '*** PASSED ***' <<< "$output"; then
	exit 0
fi
exit 1

//--- sim.f
design/rpc_router_pkg.sv
design/rpc_rx_fifo.sv
design/rpc_rx_port.sv
design/rpc_tx_arbiter.sv
design/rpc_router_crossbar.sv
tests/rpc_router_tb.sv

//--- tests/rpc_router_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rpc_router_tb;
	import rpc_router_pkg::*;

	localparam int         CHILD_COUNT = 2;
	localparam logic [3:0] PRESENT     = 4'b1110;
	localparam logic [3:0] X_POS       = 4'd2;
	localparam logic [3:0] Y_POS       = 4'd2;
	localparam int         PORTS       = NEIGHBOR_COUNT + CHILD_COUNT;
	// Messages sent over all phases, sizes the watchdog
	localparam int         MSG_TOTAL   = 47;
	// Longest wait for the outputs to empty the scoreboard after a phase
	localparam int         DRAIN_LIMIT = 256;

	logic                  clk;
	logic                  rst_n;
	rpc_link_t [PORTS-1:0] in_link;
	logic [PORTS-1:0]      in_ready;
	rpc_link_t [PORTS-1:0] out_link;
	logic [PORTS-1:0]      out_ready;

	int               seed = 32'hf209;
	int               errors;
	int               dropped;
	logic [15:0]      next_tag;
	logic             rand_ready;
	logic             rand_gaps;
	logic             stall_child0;
	logic             check_alt;
	logic [PORTS-1:0] saw_full;

	// Expected words per output and source, index out*PORTS+src
	logic [WORD_W-1:0] exp_q [PORTS*PORTS][$];
	int                cur_src [PORTS];
	int                last_src [PORTS];
	int                word_cnt [PORTS];

	rpc_router_crossbar #(
		.CHILD_COUNT      (CHILD_COUNT),
		.NEIGHBOR_PRESENT (PRESENT),
		.X_POS            (X_POS),
		.Y_POS            (Y_POS),
		.FIFO_DEPTH       (8)
	) i_rpc_router_crossbar (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_link   (in_link),
		.in_ready  (in_ready),
		.out_link  (out_link),
		.out_ready (out_ready)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Reference model

	// Output port for an address, -1 when the router discards it
	function automatic int route_of(input rpc_addr_t a);
		int o;
		if (a.x == X_POS && a.y == Y_POS) begin
			if (a.child < 8'(CHILD_COUNT)) begin
				return NEIGHBOR_COUNT + int'(a.child);
			end
			return -1;
		end
		// X resolved before Y
		if (a.x > X_POS) o = int'(PORT_EAST);
		else if (a.x < X_POS) o = int'(PORT_WEST);
		else if (a.y > Y_POS) o = int'(PORT_NORTH);
		else o = int'(PORT_SOUTH);
		return PRESENT[o] ? o : -1;
	endfunction

	function automatic rpc_addr_t make_addr(input int x, input int y, input int child);
		rpc_addr_t a;
		a.x     = 4'(x);
		a.y     = 4'(y);
		a.child = 8'(child);
		return a;
	endfunction

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Words still owed by the DUT
	function automatic int pending();
		int n;
		n = 0;
		for (int i = 0; i < PORTS*PORTS; i++) n += exp_q[i].size();
		return n;
	endfunction

	//////////////////////////////////////////////////
	// Stimulus, entered and left at 1 ns past a rising edge

	task automatic send_msg(input int src, input rpc_addr_t dst);
		logic [WORD_W-1:0] words [MESSAGE_WORDS];
		int                o;
		logic              taken;
		// Low half of the header is a unique tag
		words[0] = {dst, next_tag};
		next_tag = next_tag + 1'b1;
		for (int w = 1; w < MESSAGE_WORDS; w++) words[w] = $random(seed);
		o = route_of(dst);
		if (o < 0) dropped++;
		else for (int w = 0; w < MESSAGE_WORDS; w++) exp_q[o*PORTS+src].push_back(words[w]);
		for (int w = 0; w < MESSAGE_WORDS; w++) begin
			// Optional idle cycles before a word
			while (rand_gaps && ($random(seed) & 3) == 0) begin
				in_link[src].valid = 1'b0;
				@(posedge clk);
				#1;
			end
			in_link[src].valid = 1'b1;
			in_link[src].data  = words[w];
			// in_ready is settled at the falling edge
			do begin
				@(negedge clk);
				taken = in_ready[src];
				@(posedge clk);
				#1;
			end while (!taken);
		end
		in_link[src].valid = 1'b0;
	endtask

	task automatic random_traffic(input int src);
		repeat (4) send_msg(src, make_addr(1 + rand_below(3), 1 + rand_below(3), rand_below(3)));
	endtask

	// Wait until every expected word has come out, or DRAIN_LIMIT cycles pass
	task automatic drain();
		int waited;
		waited = 0;
		while (pending() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		repeat (4) @(posedge clk);
		#1;
	endtask

	// Output ready, random or held high, child 0 can be stalled
	initial begin
		out_ready = '1;
		forever begin
			@(posedge clk);
			#1;
			if (rand_ready) out_ready = PORTS'($random(seed) | $random(seed));
			else out_ready = '1;
			if (stall_child0) out_ready[NEIGHBOR_COUNT] = 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Output monitor, a word moves at the next rising edge

	always @(negedge clk) begin : monitor
		int                src;
		int                idx;
		logic              other;
		logic              exp_any;
		logic [WORD_W-1:0] exp_w;
		logic [WORD_W-1:0] d;
		if (rst_n) begin
			for (int o = 0; o < PORTS; o++) begin
				// Input side full flag
				if (!in_ready[o]) saw_full[o] = 1'b1;
				if (out_link[o].valid && out_ready[o]) begin
					d = out_link[o].data;
					if (cur_src[o] < 0) begin
						// New message, source found by its unique header
						src     = -1;
						exp_any = 1'b0;
						exp_w   = '0;
						for (int s = 0; s < PORTS; s++) begin
							idx = o*PORTS + s;
							if (exp_q[idx].size() > 0) begin
								if (!exp_any) exp_w = exp_q[idx][0];
								exp_any = 1'b1;
								if (src < 0 && exp_q[idx][0] == d) src = s;
							end
						end
						assert (src >= 0) else begin
							errors++;
							if (exp_any) begin
								$display("mismatch out_link[%0d].data: expected %h, actual %h",
									o, exp_w, d);
							end else begin
								$display("output %0d sent a word no message was routed to: %h",
									o, d);
							end
						end
						if (src >= 0) begin
							// Same source twice while another waits breaks round robin
							if (check_alt && last_src[o] == src) begin
								other = 1'b0;
								for (int s = 0; s < PORTS; s++) begin
									if (s != src && exp_q[o*PORTS+s].size() > 0) other = 1'b1;
								end
								assert (!other) else begin
									errors++;
									$display("output %0d served input %0d twice while another waited",
										o, src);
								end
							end
							cur_src[o]  = src;
							last_src[o] = src;
							word_cnt[o] = 1;
							void'(exp_q[o*PORTS+src].pop_front());
						end
					end else begin
						// Rest of the message must come from the same source
						idx     = o*PORTS + cur_src[o];
						exp_any = exp_q[idx].size() > 0;
						exp_w   = '0;
						if (exp_any) exp_w = exp_q[idx][0];
						assert (exp_any && exp_w == d) else begin
							errors++;
							$display("mismatch out_link[%0d].data: expected %h, actual %h",
								o, exp_w, d);
						end
						if (exp_any) void'(exp_q[idx].pop_front());
						word_cnt[o]++;
						if (word_cnt[o] == MESSAGE_WORDS) cur_src[o] = -1;
					end
				end
			end
		end
	end

	// Watchdog
	initial begin
		repeat (MSG_TOTAL * 64) @(posedge clk);
		$display("timeout: traffic still pending after %0d cycles", MSG_TOTAL * 64);
		$display("*** FAILED ***");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic any_valid;
		rst_n        = 1'b0;
		in_link      = '0;
		rand_ready   = 1'b0;
		rand_gaps    = 1'b0;
		stall_child0 = 1'b0;
		check_alt    = 1'b0;
		saw_full     = '0;
		errors       = 0;
		dropped      = 0;
		next_tag     = '0;
		for (int o = 0; o < PORTS; o++) begin
			cur_src[o]  = -1;
			last_src[o] = -1;
			word_cnt[o] = 0;
		end
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Idle outputs, empty FIFOs ready
		@(negedge clk);
		any_valid = 1'b0;
		for (int o = 0; o < PORTS; o++) any_valid |= out_link[o].valid;
		assert (!any_valid && in_ready == '1) else begin
			errors++;
			$display("after reset an output was valid or an input was not ready");
		end
		@(posedge clk);
		#1;

		// Local delivery, every input to a child
		for (int s = 0; s < PORTS; s++) send_msg(s, make_addr(2, 2, s % 2));
		drain();

		// Neighbor routing from child 0
		send_msg(4, make_addr(3, 2, 0));
		send_msg(4, make_addr(2, 1, 0));
		send_msg(4, make_addr(2, 3, 5));
		send_msg(4, make_addr(5, 0, 1));
		drain();

		// Bad child, absent west, bad child, then a good one
		send_msg(5, make_addr(2, 2, 2));
		send_msg(5, make_addr(1, 2, 0));
		send_msg(5, make_addr(2, 2, 7));
		send_msg(5, make_addr(2, 2, 0));
		drain();

		// Three inputs fight for child 1
		check_alt = 1'b1;
		fork
			repeat (2) send_msg(0, make_addr(2, 2, 1));
			repeat (2) send_msg(1, make_addr(2, 2, 1));
			repeat (2) send_msg(2, make_addr(2, 2, 1));
		join
		drain();
		check_alt = 1'b0;

		// Random destinations, gaps and back-pressure on all ports
		rand_ready = 1'b1;
		rand_gaps  = 1'b1;
		fork
			random_traffic(0);
			random_traffic(1);
			random_traffic(2);
			random_traffic(3);
			random_traffic(4);
			random_traffic(5);
		join
		drain();

		// Child 0 stalled until input 2 has filled its FIFO
		rand_ready   = 1'b0;
		rand_gaps    = 1'b0;
		saw_full     = '0;
		stall_child0 = 1'b1;
		fork
			repeat (3) send_msg(2, make_addr(2, 2, 0));
			begin
				repeat (40) @(posedge clk);
				assert (saw_full[2]) else begin
					errors++;
					$display("in_ready of input 2 never fell while its output was stalled");
				end
				stall_child0 = 1'b0;
			end
		join
		drain();

		assert (pending() == 0) else begin
			errors++;
			$display("%0d expected words never arrived", pending());
		end
		$display("errors: %0d, dropped messages: %0d", errors, dropped);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire
